/* hdl/rr_sched_cfg.svh */
// Round-robin request scheduler configuration.
// Sizes shared by the package and every RTL block of the scheduler.

`ifndef RR_SCHED_CFG_SVH
`define RR_SCHED_CFG_SVH

// Number of request channels served by the arbiter.
`define RR_NUM_CH 20

// Width of a channel number.
// It must hold every value from 0 to RR_NUM_CH-1.
`define RR_CH_BITS 5

// Width of each pending counter.
// A counter saturates at all ones, which is 15 here.
`define RR_PEND_BITS 4

`endif

/* hdl/rr_sched_pkg.sv */
// Round-robin request scheduler types.
// Holds the channel number, the per-channel mask and the grant record.

`default_nettype none

`include "rr_sched_cfg.svh"

package rr_sched_pkg;

	// Number of one channel, always in the range 0 to RR_NUM_CH-1.
	typedef logic [`RR_CH_BITS-1:0] ch_id_t;

	// One bit per channel.
	// Bit n belongs to channel n.
	typedef logic [`RR_NUM_CH-1:0] ch_mask_t;

	// Grant record as it leaves the scheduler.
	// The valid bit is high for one cycle per grant, and id names the winner.
	typedef struct packed {
		logic   valid;
		ch_id_t id;
	} grant_t;

endpackage

`default_nettype wire

/* hdl/req_pend_bank.sv */
// Pending request store for the round-robin scheduler.
// One saturating counter per channel counts requests not yet granted.
// A request that finds its counter full is dropped and leaves a sticky
// overflow flag behind.

`timescale 1ns/1ps
`default_nettype none

`include "rr_sched_cfg.svh"

module req_pend_bank (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rr_sched_pkg::ch_mask_t req,
	input  logic                   take,
	input  rr_sched_pkg::ch_id_t   take_id,
	output rr_sched_pkg::ch_mask_t pend_mask,
	output rr_sched_pkg::ch_mask_t ovf
);

	// Value at which a counter stops counting up.
	localparam logic [`RR_PEND_BITS-1:0] CNT_MAX = {`RR_PEND_BITS{1'b1}};

	// Pending count of each channel.
	logic [`RR_PEND_BITS-1:0] cnt [`RR_NUM_CH];

	// One-hot form of the consume strobe.
	rr_sched_pkg::ch_mask_t dec_mask;

	always_comb begin
		dec_mask = '0;
		if (take) begin
			dec_mask[take_id] = 1'b1;
		end
	end

	// Each channel sees a request bit and a consume bit in the same cycle.
	// Both together leave the count where it is.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `RR_NUM_CH; i++) begin
				cnt[i] <= '0;
			end
			ovf <= '0;
		end else begin
			for (int i = 0; i < `RR_NUM_CH; i++) begin
				case ({req[i], dec_mask[i]})
					2'b10: begin
						// A full counter drops the pulse and flags it.
						if (cnt[i] == CNT_MAX) begin
							ovf[i] <= 1'b1;
						end else begin
							cnt[i] <= cnt[i] + 1'b1;
						end
					end
					2'b01: begin
						cnt[i] <= cnt[i] - 1'b1;
					end
					default: begin
						cnt[i] <= cnt[i];
					end
				endcase
			end
		end
	end

	// A channel has work while its count is nonzero.
	always_comb begin
		for (int i = 0; i < `RR_NUM_CH; i++) begin
			pend_mask[i] = |cnt[i];
		end
	end

	// The arbiter only picks channels that are pending here.
	// A consume on an empty counter would wrap it to full.
	a_take_pending : assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> pend_mask[take_id]
	);

	// The consume channel comes from the arbiter pointer logic.
	a_take_id_range : assert property (
		@(posedge clk) disable iff (!rst_n)
		take |-> (take_id < `RR_CH_BITS'(`RR_NUM_CH))
	);

endmodule

`default_nettype wire

/* hdl/rr_arb20.sv */
// Round-robin arbiter for the request scheduler.
// A pointer holds the last granted channel, and the search starts at the
// channel after it and wraps around, so the pointer's own channel comes last.
// The next pointer is kept in the range 0 to RR_NUM_CH-1.

`timescale 1ns/1ps
`default_nettype none

`include "rr_sched_cfg.svh"

module rr_arb20 (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rr_sched_pkg::ch_mask_t req,
	input  logic                   en,
	output rr_sched_pkg::ch_id_t   sel,
	output logic                   gnt
);

	// Pointer to the channel that won the last arbitration.
	rr_sched_pkg::ch_id_t arb_ptr;

	// Request mask turned so that bit 0 is the pointer's channel.
	rr_sched_pkg::ch_mask_t rot_req;

	// Distance from the pointer to the winner.
	rr_sched_pkg::ch_id_t pri_off;

	// Pointer plus offset, one bit wider so that the wrap can be seen.
	logic [`RR_CH_BITS:0] ptr_sum;

	// Winner after the wrap, which is also the next pointer.
	rr_sched_pkg::ch_id_t n_ptr;

	// Rotates din right by amt places over RR_NUM_CH bits.
	// Each stage turns the mask by a power of two, as a barrel shifter does.
	// The amount never exceeds RR_NUM_CH-1, so the stages never wrap twice.
	function automatic rr_sched_pkg::ch_mask_t rot_right(
		input rr_sched_pkg::ch_mask_t din,
		input rr_sched_pkg::ch_id_t   amt
	);
		logic [2*`RR_NUM_CH-1:0] dbl;
		rr_sched_pkg::ch_mask_t  r;
		r = din;
		for (int k = 0; k < `RR_CH_BITS; k++) begin
			if (amt[k]) begin
				// Two copies side by side make the wrap a plain slice.
				dbl = {r, r};
				r = dbl[(1 << k) +: `RR_NUM_CH];
			end
		end
		return r;
	endfunction

	// Finds the lowest set bit among positions 1 and up.
	// Bit 0 is the pointer's own channel, which only wins when it is the
	// sole requester, and then the offset of 0 is already right.
	function automatic rr_sched_pkg::ch_id_t pri_pick(
		input rr_sched_pkg::ch_mask_t din
	);
		rr_sched_pkg::ch_id_t off;
		off = '0;
		// Scanning downwards lets the lowest set bit write last.
		for (int i = `RR_NUM_CH - 1; i >= 1; i--) begin
			if (din[i]) begin
				off = rr_sched_pkg::ch_id_t'(i);
			end
		end
		return off;
	endfunction

	assign rot_req = rot_right(req, arb_ptr);
	assign pri_off = pri_pick(rot_req);

	// The sum reaches at most 2*(RR_NUM_CH-1), so one subtraction reduces it.
	assign ptr_sum = {1'b0, arb_ptr} + {1'b0, pri_off};

	always_comb begin
		if (ptr_sum >= (`RR_CH_BITS+1)'(`RR_NUM_CH)) begin
			n_ptr = rr_sched_pkg::ch_id_t'(ptr_sum - (`RR_CH_BITS+1)'(`RR_NUM_CH));
		end else begin
			n_ptr = ptr_sum[`RR_CH_BITS-1:0];
		end
	end

	// The selection is combinational so the caller can consume in the same cycle.
	assign sel = n_ptr;

	// The pointer only moves when a grant is actually taken.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			arb_ptr <= '0;
			gnt     <= 1'b0;
		end else begin
			if (en) begin
				arb_ptr <= n_ptr;
			end
			gnt <= en & (|req);
		end
	end

	// The modulo update must keep the pointer inside the channel range.
	a_ptr_range : assert property (
		@(posedge clk) disable iff (!rst_n)
		arb_ptr < `RR_CH_BITS'(`RR_NUM_CH)
	);

	// Whatever the pointer, the rotate and pick must land on a real requester.
	a_sel_req : assert property (
		@(posedge clk) disable iff (!rst_n)
		(|req) |-> req[sel]
	);

endmodule

`default_nettype wire

/* hdl/rr_sched_top.sv */
// Round-robin request scheduler top level.
// Joins the pending store with the arbiter and registers the grant.
// A grant is taken in any cycle where slot is high and some channel waits.

`timescale 1ns/1ps
`default_nettype none

`include "rr_sched_cfg.svh"

module rr_sched_top (
	input  logic                   clk,
	input  logic                   rst_n,
	input  rr_sched_pkg::ch_mask_t req,
	input  logic                   slot,
	output rr_sched_pkg::grant_t   grant,
	output rr_sched_pkg::ch_mask_t ovf
);

	// Channels with a nonzero pending count.
	rr_sched_pkg::ch_mask_t pend_mask;

	// Winner of this cycle, from the arbiter.
	rr_sched_pkg::ch_id_t sel;

	// High in a cycle that issues a grant.
	logic take;

	assign take = slot & (|pend_mask);

	req_pend_bank u_pend (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.take      (take),
		.take_id   (sel),
		.pend_mask (pend_mask),
		.ovf       (ovf)
	);

	// The arbiter's gnt equals the registered take, which grant.valid holds.
	rr_arb20 u_arb (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (pend_mask),
		.en    (take),
		.sel   (sel),
		.gnt   ()
	);

	// The grant leaves one cycle after its slot, at the same edge that
	// consumes the request and moves the pointer.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			grant.valid <= 1'b0;
			grant.id    <= {`RR_CH_BITS{1'b0}};
		end else begin
			grant.valid <= take;
			grant.id    <= sel;
		end
	end

endmodule

`default_nettype wire

/* bench/rr_sched_tb.sv */
// Testbench for the round-robin request scheduler.
// A reference model tracks pending counts, overflow flags and the pointer,
// and concurrent assertions compare grant and ovf with it every cycle.

`timescale 1ns/1ps
`default_nettype none

`include "rr_sched_cfg.svh"

module rr_sched_tb;

	// Cycle budget of each test, used for the run limit.
	localparam int LEN_RESET  = 20;
	localparam int LEN_SINGLE = 30;
	localparam int LEN_FAIR   = 85;
	localparam int LEN_BACKP  = 220;
	localparam int LEN_SAT    = 45;
	localparam int LEN_RAND   = 2310;
	localparam int TIMEOUT = LEN_RESET + LEN_SINGLE + LEN_FAIR + LEN_BACKP + LEN_SAT
		+ LEN_RAND + 200;
	localparam int NUM_CH   = `RR_NUM_CH;
	localparam int PEND_MAX = (1 << `RR_PEND_BITS) - 1;

	logic                   clk;
	logic                   rst_n;
	rr_sched_pkg::ch_mask_t req;
	logic                   slot;
	rr_sched_pkg::grant_t   grant;
	rr_sched_pkg::ch_mask_t ovf;

	// Model state, updated at each rising edge.
	int                     mdl_cnt [NUM_CH];
	int                     mdl_ptr;
	rr_sched_pkg::ch_mask_t mdl_ovf;

	// Expected outputs for the cycle after each edge.
	logic                   exp_valid;
	rr_sched_pkg::ch_id_t   exp_id;
	rr_sched_pkg::ch_mask_t exp_ovf;

	int err_cnt = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	int gnt_seen = 0;
	int cyc = 0;

	initial clk = 1'b0;
	always #2 clk = ~clk;

	rr_sched_top i_rr_sched_top (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.slot  (slot),
		.grant (grant),
		.ovf   (ovf)
	);

	// The winner is the first channel with work after the pointer, and the
	// pointer's own channel is tried last.
	always @(posedge clk or negedge rst_n) begin : ref_model
		int   win;
		int   c;
		logic found;
		logic take;
		logic inc;
		logic dec;
		if (!rst_n) begin
			for (int i = 0; i < NUM_CH; i++) begin
				mdl_cnt[i] = 0;
			end
			mdl_ptr = 0;
			mdl_ovf = '0;
			exp_valid <= 1'b0;
			exp_id    <= '0;
			exp_ovf   <= '0;
		end else begin
			found = 1'b0;
			win = 0;
			for (int k = 1; k <= NUM_CH; k++) begin
				c = (mdl_ptr + k) % NUM_CH;
				if (!found && mdl_cnt[c] != 0) begin
					found = 1'b1;
					win = c;
				end
			end
			take = slot && found;
			for (int i = 0; i < NUM_CH; i++) begin
				inc = req[i];
				dec = take && (i == win);
				// A pulse and a consume together cancel out.
				if (inc && !dec) begin
					if (mdl_cnt[i] == PEND_MAX) begin
						mdl_ovf[i] = 1'b1;
					end else begin
						mdl_cnt[i] = mdl_cnt[i] + 1;
					end
				end else if (dec && !inc) begin
					mdl_cnt[i] = mdl_cnt[i] - 1;
				end
			end
			if (take) begin
				mdl_ptr = win;
			end
			exp_valid <= take;
			exp_id    <= rr_sched_pkg::ch_id_t'(win);
			exp_ovf   <= mdl_ovf;
		end
	end

	// Counts grants as they leave the DUT.
	always @(posedge clk) begin
		if (rst_n && grant.valid) begin
			gnt_seen++;
		end
	end

	// Ends the run if the tests overrun their budget.
	always @(posedge clk) begin
		cyc++;
		if (cyc > TIMEOUT) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// Reset clears the grant register and the overflow flags.
	a_reset_valid : assert property (
		@(posedge clk) !rst_n |-> grant.valid == 1'b0
	) else begin
		err_cnt++;
		$display("ERR grant.valid: got %h expected 0 while reset is held",
			$sampled(grant.valid));
	end

	a_reset_ovf : assert property (
		@(posedge clk) !rst_n |-> ovf == '0
	) else begin
		err_cnt++;
		$display("ERR ovf: got %h expected 0 while reset is held", $sampled(ovf));
	end

	a_grant_valid : assert property (
		@(posedge clk) disable iff (!rst_n) grant.valid == exp_valid
	) else begin
		err_cnt++;
		$display("ERR grant.valid: got %h expected %h",
			$sampled(grant.valid), $sampled(exp_valid));
	end

	a_grant_id : assert property (
		@(posedge clk) disable iff (!rst_n) grant.valid |-> grant.id == exp_id
	) else begin
		err_cnt++;
		$display("ERR grant.id: got %h expected %h", $sampled(grant.id), $sampled(exp_id));
	end

	a_ovf : assert property (
		@(posedge clk) disable iff (!rst_n) ovf == exp_ovf
	) else begin
		err_cnt++;
		$display("ERR ovf: got %h expected %h", $sampled(ovf), $sampled(exp_ovf));
	end

	// No grant may follow a cycle without a slot.
	a_slot_gate : assert property (
		@(posedge clk) disable iff (!rst_n) grant.valid |-> $past(slot)
	) else begin
		err_cnt++;
		$display("grant issued although slot was low in the cycle before");
	end

	// Waits n rising edges and returns 1 ns after the last one.
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		req = '0;
		slot = 1'b0;
		repeat (10) @(posedge clk);
		#1;
		rst_n = 1'b1;
	endtask

	function automatic int model_total();
		int s;
		s = 0;
		for (int i = 0; i < NUM_CH; i++) begin
			s += mdl_cnt[i];
		end
		return s;
	endfunction

	// Holds slot high until the model has nothing pending and the last
	// grant has left the DUT.
	task automatic drain();
		slot = 1'b1;
		while (model_total() != 0) begin
			step(1);
		end
		step(2);
		slot = 1'b0;
	endtask

	task automatic check_value(input string name, input int got, input int expv);
		assert (got == expv) else begin
			err_cnt++;
			$display("ERR %s: got %h expected %h", name, got, expv);
		end
	endtask

	task automatic finish_test(input int num, input string name, input int errs0);
		int e;
		e = err_cnt - errs0;
		if (e == 0) begin
			pass_cnt++;
		end else begin
			fail_cnt++;
		end
		$display("test %0d %s: %s, %0d errors", num, name, (e == 0) ? "ok" : "bad", e);
	endtask

	initial begin : stim
		int unsigned            rnd;
		int unsigned            rnd2;
		int                     errs0;
		int                     base;
		int                     pend;
		rr_sched_pkg::ch_mask_t one_ch;
		rnd = $urandom(70);
		rst_n = 1'b0;
		req = '0;
		slot = 1'b0;

		errs0 = err_cnt;
		apply_reset();
		step(5);
		finish_test(1, "reset", errs0);

		// Five spaced pulses on channel 7, each served on its own.
		errs0 = err_cnt;
		base = gnt_seen;
		one_ch = '0;
		one_ch[7] = 1'b1;
		slot = 1'b1;
		for (int p = 0; p < 5; p++) begin
			req = one_ch;
			step(1);
			req = '0;
			step(2);
		end
		drain();
		check_value("grant count", gnt_seen - base, 5);
		finish_test(2, "single channel", errs0);

		// A fresh reset puts the pointer back on channel 0.
		errs0 = err_cnt;
		apply_reset();
		for (int p = 0; p < 3; p++) begin
			req = '1;
			step(1);
		end
		req = '0;
		drain();
		finish_test(3, "fairness", errs0);

		errs0 = err_cnt;
		for (int p = 0; p < 10; p++) begin
			rnd = $urandom;
			rnd2 = $urandom;
			req = rr_sched_pkg::ch_mask_t'(rnd & rnd2);
			step(1);
		end
		req = '0;
		step(3);
		pend = model_total();
		base = gnt_seen;
		drain();
		check_value("grant count", gnt_seen - base, pend);
		finish_test(4, "back-pressure", errs0);

		// Eighteen pulses on channel 3 overflow its counter.
		errs0 = err_cnt;
		one_ch = '0;
		one_ch[3] = 1'b1;
		for (int p = 0; p < 18; p++) begin
			req = one_ch;
			step(1);
		end
		req = '0;
		step(1);
		check_value("ovf[3]", int'(ovf[3]), 1);
		base = gnt_seen;
		drain();
		check_value("grant count", gnt_seen - base, PEND_MAX);
		finish_test(5, "saturation", errs0);

		errs0 = err_cnt;
		for (int p = 0; p < 2000; p++) begin
			rnd = $urandom;
			rnd2 = $urandom;
			req = rr_sched_pkg::ch_mask_t'(rnd & rnd2);
			rnd = $urandom;
			slot = rnd[0];
			step(1);
		end
		req = '0;
		drain();
		finish_test(6, "random mix", errs0);

		$display("tests: %0d ok, %0d bad, %0d check errors", pass_cnt, fail_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rr_sched.f */
+incdir+hdl
hdl/rr_sched_pkg.sv
hdl/req_pend_bank.sv
hdl/rr_arb20.sv
hdl/rr_sched_top.sv
bench/rr_sched_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the round-robin scheduler testbench with Verilator and runs it.
# The run counts as passed only if the pass line shows up in the output.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module rr_sched_tb \
	-f rr_sched.f \
	-o rr_sched_sim

out=$(./obj_dir/rr_sched_sim)
echo "$out"

if echo "$out" | grep -qx "TESTBENCH PASSED"; then
	exit 0
else
	echo "simulation did not report a pass"
	exit 1
fi
